// ==== uart_periph.f ====
+incdir+include
hw/uart_pkg.sv
hw/uart_fifo.sv
hw/uart_bus_ctrl.sv
hw/uart_reg_bank.sv
hw/uart_tx.sv
hw/uart_rx.sv
hw/uart_periph.sv
tests/uart_periph_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module uart_periph_tb -f uart_periph.f -o uart_periph_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/uart_periph_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Test FAILED" "$log"; then
  exit 1
fi

exit 0

// ==== tests/uart_periph_tb.sv ====
`timescale 1ns/100ps
`include "uart_defs.svh"

module uart_periph_tb;

  import uart_pkg::*;

  localparam int DivTest = 15;
  localparam int Iters = 6;
  // Frames over the whole run plus the idle checks
  localparam int MaxFrames = 2 * 6 + 6 + 8 + 10 + Iters * 16;
  localparam longint TimeoutNs = longint'(MaxFrames) * 12 * (DivTest + 1) * 8 + 100000;

  logic       clock;
  logic       reset;
  uart_addr_t addr;
  uart_word_t wr_data;
  logic       wr_en;
  logic       rd_en;
  uart_word_t rd_data;
  logic       rd_valid;
  logic       tx;
  logic       rx;
  logic       irq;

  int          data_errors;
  int          other_errors;
  logic [31:0] lcg_state;

  // Reference model of the register bank and both FIFOs
  uart_byte_t  m_txdata;
  uart_byte_t  m_rxdata;
  logic        m_rx_empty;
  logic        m_txen;
  logic        m_nstop;
  logic        m_rxen;
  logic [2:0]  m_txcnt;
  logic [2:0]  m_rxcnt;
  logic [1:0]  m_ie;
  logic [15:0] m_div;
  uart_byte_t  tx_model_q[$];
  uart_byte_t  rx_model_q[$];

  // Filled by the tx line monitor
  uart_byte_t  tx_seen[$];
  int          stop_gaps[$];

  uart_periph i_dut (
    .clock    (clock),
    .reset    (reset),
    .addr     (addr),
    .wr_data  (wr_data),
    .wr_en    (wr_en),
    .rd_en    (rd_en),
    .rd_data  (rd_data),
    .rd_valid (rd_valid),
    .tx       (tx),
    .rx       (rx),
    .irq      (irq)
  );

  initial begin
    clock = 1'b0;
  end

  always #4 clock = ~clock;

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic int rand_below(input int n);
    return int'(next_rand() >> 8) % n;
  endfunction

  function automatic logic [1:0] expected_ip();
    logic tx_pend;
    logic rx_pend;
    tx_pend = (tx_model_q.size() < int'(m_txcnt)) && m_ie[0];
    rx_pend = (rx_model_q.size() > int'(m_rxcnt)) && m_ie[1];
    return {rx_pend, tx_pend};
  endfunction

  function automatic uart_word_t expect_read(input uart_addr_t a);
    logic full;
    full = (tx_model_q.size() == `UART_FIFO_DEPTH);
    case (a)
      TXDATA: return {full, 23'b0, m_txdata};
      RXDATA: begin
        // A read of an empty FIFO keeps the old byte
        m_rx_empty = (rx_model_q.size() == 0);
        if (!m_rx_empty) begin
          m_rxdata = rx_model_q.pop_front();
        end
        return {m_rx_empty, 23'b0, m_rxdata};
      end
      TXCTRL:  return {13'b0, m_txcnt, 14'b0, m_nstop, m_txen};
      RXCTRL:  return {13'b0, m_rxcnt, 15'b0, m_rxen};
      IE:      return {30'b0, m_ie};
      IP:      return {30'b0, expected_ip()};
      DIV:     return {16'b0, m_div};
      default: return '0;
    endcase
  endfunction

  task automatic model_write(input uart_addr_t a, input uart_word_t d);
    case (a)
      TXDATA: begin
        m_txdata = d[7:0];
        if (tx_model_q.size() < `UART_FIFO_DEPTH) begin
          tx_model_q.push_back(d[7:0]);
        end
      end
      TXCTRL: begin
        m_txen  = d[0];
        m_nstop = d[1];
        m_txcnt = d[18:16];
      end
      RXCTRL: begin
        m_rxen  = d[0];
        m_rxcnt = d[18:16];
      end
      IE:      m_ie = d[1:0];
      DIV:     m_div = d[15:0];
      default: ;
    endcase
  endtask

  task automatic bus_write(input uart_addr_t a, input uart_word_t d);
    @(posedge clock);
    addr    <= a;
    wr_data <= d;
    wr_en   <= 1'b1;
    @(posedge clock);
    wr_en <= 1'b0;
    model_write(a, d);
  endtask

  task automatic bus_read(input uart_addr_t a, output uart_word_t value);
    int   waited;
    logic seen;
    @(posedge clock);
    addr  <= a;
    rd_en <= 1'b1;
    @(posedge clock);
    rd_en <= 1'b0;
    waited = 0;
    seen   = 1'b0;
    value  = 'x;
    while (!seen && waited < 8) begin
      @(negedge clock);
      if (rd_valid === 1'b1) begin
        value = rd_data;
        seen  = 1'b1;
      end
      waited++;
    end
    if (!seen) begin
      other_errors++;
      $display("Read of address %0d never returned rd_valid", a);
    end else if (waited != 2) begin
      other_errors++;
      $display("Read of address %0d gave rd_valid after %0d cycles, expected 2", a, waited);
    end
  endtask

  task automatic check_read(input uart_addr_t a);
    uart_word_t got;
    uart_word_t exp;
    bus_read(a, got);
    exp = expect_read(a);
    if (got !== exp) begin
      data_errors++;
      $display("mismatch at %0t: address %0d read %08h, expected %08h", $time, a, got, exp);
    end
  endtask

  task automatic check_ip_irq();
    check_read(IP);
    @(negedge clock);
    if (irq !== (|expected_ip())) begin
      data_errors++;
      $display("mismatch at %0t: irq is %b, expected %b", $time, irq, |expected_ip());
    end
  endtask

  // 8N1 frame on rx, LSB first
  task automatic send_frame(input uart_byte_t value);
    int   t;
    int   b;
    logic level;
    t = m_div + 1;
    for (b = 0; b < 10; b++) begin
      if (b == 0) level = 1'b0;
      else if (b == 9) level = 1'b1;
      else level = value[b - 1];
      @(posedge clock);
      rx <= level;
      repeat (t - 1) @(posedge clock);
    end
    if (m_rxen && rx_model_q.size() < `UART_FIFO_DEPTH) begin
      rx_model_q.push_back(value);
    end
  endtask

  task automatic wait_rx_level();
    int waited;
    waited = 0;
    @(negedge clock);
    while (i_dut.rx_level != uart_level_t'(rx_model_q.size()) && waited < 1000) begin
      @(negedge clock);
      waited++;
    end
    if (waited == 1000) begin
      other_errors++;
      $display("Receive FIFO never reached %0d entries", rx_model_q.size());
    end
  endtask

  task automatic clear_line_queues();
    tx_seen.delete();
    stop_gaps.delete();
  endtask

  task automatic check_tx_burst(input int n, input logic check_gaps);
    int waited;
    int limit;
    int bit_t;
    int stops;
    int i;
    bit_t  = m_div + 1;
    limit  = n * 12 * bit_t + 100;
    waited = 0;
    while (tx_seen.size() < n && waited < limit) begin
      @(negedge clock);
      waited++;
    end
    if (tx_seen.size() < n) begin
      other_errors++;
      $display("Only %0d of %0d frames appeared on tx", tx_seen.size(), n);
    end
    for (i = 0; i < tx_seen.size() && i < tx_model_q.size(); i++) begin
      if (tx_seen[i] !== tx_model_q[i]) begin
        data_errors++;
        $display("mismatch at %0t: tx frame %0d is %02h, expected %02h",
                 $time, i, tx_seen[i], tx_model_q[i]);
      end
    end
    // Frames after the first follow back to back
    stops = m_nstop ? 2 : 1;
    for (i = 1; check_gaps && i < stop_gaps.size(); i++) begin
      if (stop_gaps[i] < stops * bit_t || stop_gaps[i] > stops * bit_t + bit_t / 2) begin
        data_errors++;
        $display("mismatch at %0t: high time %0d clocks before frame %0d, %0d stop bits",
                 $time, stop_gaps[i], i, stops);
      end
    end
    tx_model_q.delete();
    clear_line_queues();
  endtask

  initial begin : line_monitor
    int         high_cnt;
    int         t;
    int         off;
    logic       early;
    logic       bit_ok;
    uart_byte_t value;
    high_cnt = 0;
    early    = 1'b0;
    @(negedge reset);
    forever begin
      @(negedge clock);
      if (tx === 1'b1) begin
        high_cnt++;
      end else begin
        stop_gaps.push_back(high_cnt);
        t      = m_div + 1;
        value  = '0;
        bit_ok = 1'b1;
        // Each bit sampled just after its start and just before its end
        for (off = 1; off < 10 * t; off++) begin
          @(negedge clock);
          if (off % t == 1) early = tx;
          if (off % t == t - 1) begin
            if (tx !== early) bit_ok = 1'b0;
            if (off / t == 0) begin
              if (tx !== 1'b0) bit_ok = 1'b0;
            end else if (off / t == 9) begin
              if (tx !== 1'b1) bit_ok = 1'b0;
            end else begin
              value[off / t - 1] = tx;
            end
          end
        end
        if (!bit_ok) begin
          data_errors++;
          $display("mismatch at %0t: frame on tx has wrong bit levels or timing", $time);
        end
        tx_seen.push_back(value);
        high_cnt = t;
      end
    end
  end

  initial begin : watchdog
    #(TimeoutNs);
    $display("Watchdog expired after %0d ns with the tests still running", TimeoutNs);
    $display("Test FAILED");
    $finish;
  end

  initial begin : main
    int         i;
    int         j;
    int         k;
    logic [2:0] wm_tx;
    logic [2:0] wm_rx;
    data_errors  = 0;
    other_errors = 0;
    lcg_state    = 32'd55;
    reset   = 1'b1;
    addr    = TXDATA;
    wr_data = '0;
    wr_en   = 1'b0;
    rd_en   = 1'b0;
    rx      = 1'b1;
    m_txdata   = '0;
    m_rxdata   = '0;
    m_rx_empty = 1'b0;
    m_txen     = 1'b0;
    m_nstop    = 1'b0;
    m_rxen     = 1'b0;
    m_txcnt    = '0;
    m_rxcnt    = '0;
    m_ie       = '0;
    // 125 MHz over 115200 baud, minus one
    m_div      = 16'd1084;
    repeat (3) @(posedge clock);
    reset <= 1'b0;

    // Reset values
    for (i = 0; i < 8; i++) begin
      check_read(uart_addr_t'(3'(i)));
    end
    if (irq !== 1'b0) begin
      data_errors++;
      $display("mismatch at %0t: irq high after reset", $time);
    end

    // Register readback
    for (i = 0; i < 4; i++) begin
      bus_write(TXCTRL, next_rand());
      check_read(TXCTRL);
      bus_write(RXCTRL, next_rand());
      check_read(RXCTRL);
      bus_write(IE, next_rand());
      check_read(IE);
      bus_write(DIV, next_rand());
      check_read(DIV);
      bus_write(IP, next_rand());
      bus_write(uart_addr_t'(3'd7), next_rand());
      check_read(IP);
      check_read(uart_addr_t'(3'd7));
    end
    bus_write(TXCTRL, '0);
    bus_write(RXCTRL, '0);
    bus_write(IE, '0);
    bus_write(DIV, DivTest);

    // Transmit with one and then two stop bits
    for (i = 0; i < 2; i++) begin
      clear_line_queues();
      bus_write(TXCTRL, {30'b0, 1'(i), 1'b1});
      for (j = 0; j < 6; j++) begin
        bus_write(TXDATA, {24'b0, 8'(rand_below(256))});
      end
      check_tx_burst(6, 1'b1);
    end

    // Receive
    bus_write(RXCTRL, 32'd1);
    for (j = 0; j < 6; j++) begin
      send_frame(8'(rand_below(256)));
    end
    wait_rx_level();
    for (j = 0; j < 7; j++) begin
      check_read(RXDATA);
    end
    bus_write(RXCTRL, '0);

    // Overflow of the transmit FIFO
    bus_write(TXCTRL, '0);
    clear_line_queues();
    for (j = 0; j < 10; j++) begin
      bus_write(TXDATA, {24'b0, 8'(rand_below(256))});
      check_read(TXDATA);
    end
    bus_write(TXCTRL, 32'd1);
    check_tx_burst(8, 1'b0);
    repeat (12 * (DivTest + 1)) @(negedge clock);
    if (tx_seen.size() != 0) begin
      data_errors++;
      $display("mismatch at %0t: %0d extra frames after overflow", $time, tx_seen.size());
    end
    check_read(TXDATA);

    // Watermark interrupts
    for (i = 0; i < Iters; i++) begin
      wm_tx = 3'(rand_below(8));
      wm_rx = 3'(rand_below(8));
      bus_write(TXCTRL, {13'b0, wm_tx, 16'b0});
      bus_write(RXCTRL, {13'b0, wm_rx, 15'b0, 1'b1});
      bus_write(IE, 32'(rand_below(4)));
      clear_line_queues();
      k = rand_below(9);
      for (j = 0; j < k; j++) begin
        bus_write(TXDATA, {24'b0, 8'(rand_below(256))});
      end
      j = rand_below(9);
      repeat (j) send_frame(8'(rand_below(256)));
      wait_rx_level();
      check_ip_irq();
      bus_write(TXCTRL, {13'b0, wm_tx, 15'b0, 1'b1});
      check_tx_burst(k, 1'b0);
      repeat (j) check_read(RXDATA);
      check_ip_irq();
    end

    $display("Errors: %0d mismatches, %0d other failures", data_errors, other_errors);
    if (data_errors == 0 && other_errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// ==== hw/uart_periph.sv ====
`timescale 1ns/100ps
`include "uart_defs.svh"

module uart_periph (
  input  logic                 clock,
  input  logic                 reset,
  input  uart_pkg::uart_addr_t addr,
  input  uart_pkg::uart_word_t wr_data,
  input  logic                 wr_en,
  input  logic                 rd_en,
  output uart_pkg::uart_word_t rd_data,
  output logic                 rd_valid,
  output logic                 tx,
  input  logic                 rx,
  output logic                 irq
);

  import uart_pkg::*;

  logic        bank_wr_en;
  logic        bank_rd_en;
  logic        rxdata_wr_en;
  logic        rx_pop;
  logic        tx_push;
  logic        tx_pop;
  logic        rx_push;
  logic        txen;
  logic        nstop;
  logic        rxen;
  logic [15:0] div;
  uart_byte_t  tx_wr_data;
  uart_byte_t  tx_rd_data;
  uart_byte_t  rx_wr_data;
  uart_byte_t  rx_rd_data;
  uart_level_t tx_level;
  uart_level_t rx_level;
  logic        tx_full;
  logic        tx_empty;
  logic        rx_empty;

  uart_bus_ctrl i_bus_ctrl (
    .clock        (clock),
    .reset        (reset),
    .addr         (addr),
    .wr_en        (wr_en),
    .rd_en        (rd_en),
    .rx_empty     (rx_empty),
    .bank_wr_en   (bank_wr_en),
    .bank_rd_en   (bank_rd_en),
    .rxdata_wr_en (rxdata_wr_en),
    .rx_pop       (rx_pop),
    .tx_push      (tx_push),
    .rd_valid     (rd_valid)
  );

  uart_reg_bank i_reg_bank (
    .clock           (clock),
    .reset           (reset),
    .addr            (addr),
    .wr_data         (wr_data),
    .rd_data         (rd_data),
    .bank_wr_en      (bank_wr_en),
    .bank_rd_en      (bank_rd_en),
    .rxdata_wr_en    (rxdata_wr_en),
    .rx_fifo_rd_data (rx_rd_data),
    .tx_fifo_wr_data (tx_wr_data),
    .tx_fifo_full    (tx_full),
    .rx_fifo_empty   (rx_empty),
    .tx_level        (tx_level),
    .rx_level        (rx_level),
    .txen            (txen),
    .nstop           (nstop),
    .rxen            (rxen),
    .div             (div),
    .irq             (irq)
  );

  uart_fifo #(.DEPTH(`UART_FIFO_DEPTH)) i_tx_fifo (
    .clock   (clock),
    .reset   (reset),
    .push    (tx_push),
    .wr_data (tx_wr_data),
    .pop     (tx_pop),
    .rd_data (tx_rd_data),
    .level   (tx_level),
    .full    (tx_full),
    .empty   (tx_empty)
  );

  // Receive overflow has no status bit
  uart_fifo #(.DEPTH(`UART_FIFO_DEPTH)) i_rx_fifo (
    .clock   (clock),
    .reset   (reset),
    .push    (rx_push),
    .wr_data (rx_wr_data),
    .pop     (rx_pop),
    .rd_data (rx_rd_data),
    .level   (rx_level),
    .full    (),
    .empty   (rx_empty)
  );

  uart_tx i_tx (
    .clock      (clock),
    .reset      (reset),
    .txen       (txen),
    .nstop      (nstop),
    .div        (div),
    .fifo_data  (tx_rd_data),
    .fifo_empty (tx_empty),
    .fifo_pop   (tx_pop),
    .tx         (tx)
  );

  uart_rx i_rx (
    .clock (clock),
    .reset (reset),
    .rxen  (rxen),
    .div   (div),
    .rx    (rx),
    .push  (rx_push),
    .data  (rx_wr_data)
  );

endmodule

// ==== hw/uart_rx.sv ====
`timescale 1ns/100ps

module uart_rx (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 rxen,
  input  logic [15:0]          div,
  input  logic                 rx,
  output logic                 push,
  output uart_pkg::uart_byte_t data
);

  import uart_pkg::*;

  typedef enum logic [1:0] {
    S_IDLE,
    S_START,
    S_DATA,
    S_STOP
  } rx_state_t;

  rx_state_t   state;
  logic        rx_s1;
  logic        rx_s2;
  logic        rx_d;
  logic [15:0] cnt;
  logic [2:0]  idx;
  uart_byte_t  shreg;
  logic        fall;
  logic        bit_done;

  assign fall     = rx_d && !rx_s2;
  assign bit_done = (cnt == div);
  assign data     = shreg;

  // Line is asynchronous to the clock
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      rx_s1 <= 1'b1;
      rx_s2 <= 1'b1;
      rx_d  <= 1'b1;
    end else begin
      rx_s1 <= rx;
      rx_s2 <= rx_s1;
      rx_d  <= rx_s2;
    end
  end

  // LSB arrives first
  always_ff @(posedge clock) begin
    if (state == S_DATA && bit_done) begin
      shreg <= {rx_s2, shreg[7:1]};
    end
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state <= S_IDLE;
      cnt   <= '0;
      idx   <= '0;
      push  <= 1'b0;
    end else begin
      push <= 1'b0;
      cnt  <= cnt + 1'b1;
      case (state)
        S_IDLE: begin
          cnt <= '0;
          if (rxen && fall) state <= S_START;
        end
        S_START: if (cnt == (div >> 1)) begin
          // Glitch shorter than half a bit is ignored
          cnt   <= '0;
          idx   <= '0;
          state <= rx_s2 ? S_IDLE : S_DATA;
        end
        S_DATA: if (bit_done) begin
          cnt <= '0;
          if (idx == 3'd7) state <= S_STOP;
          else idx <= idx + 1'b1;
        end
        S_STOP: if (bit_done) begin
          // Stop level is not checked
          push  <= rxen;
          state <= S_IDLE;
        end
        default: state <= S_IDLE;
      endcase
    end
  end

endmodule

// ==== hw/uart_tx.sv ====
`timescale 1ns/100ps

module uart_tx (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 txen,
  input  logic                 nstop,
  input  logic [15:0]          div,
  input  uart_pkg::uart_byte_t fifo_data,
  input  logic                 fifo_empty,
  output logic                 fifo_pop,
  output logic                 tx
);

  import uart_pkg::*;

  typedef enum logic [1:0] {
    S_IDLE,
    S_START,
    S_DATA,
    S_STOP
  } tx_state_t;

  tx_state_t  state;
  logic [15:0] cnt;
  logic [2:0] idx;
  logic       two_stop;
  uart_byte_t shreg;
  logic       bit_done;

  assign bit_done = (cnt == div);
  // New frame only from idle
  assign fifo_pop = (state == S_IDLE) && txen && !fifo_empty;

  always_ff @(posedge clock) begin
    if (fifo_pop) begin
      shreg <= fifo_data;
    end else if (state == S_DATA && bit_done) begin
      shreg <= shreg >> 1;
    end
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state    <= S_IDLE;
      cnt      <= '0;
      idx      <= '0;
      two_stop <= 1'b0;
      tx       <= 1'b1;
    end else begin
      cnt <= bit_done ? '0 : cnt + 1'b1;
      case (state)
        S_IDLE: begin
          cnt <= '0;
          if (fifo_pop) begin
            state    <= S_START;
            two_stop <= nstop;
            tx       <= 1'b0;
          end
        end
        S_START: if (bit_done) begin
          state <= S_DATA;
          idx   <= '0;
          tx    <= shreg[0];
        end
        S_DATA: if (bit_done) begin
          if (idx == 3'd7) begin
            state <= S_STOP;
            tx    <= 1'b1;
          end else begin
            idx <= idx + 1'b1;
            tx  <= shreg[1];
          end
        end
        S_STOP: if (bit_done) begin
          if (two_stop) two_stop <= 1'b0;
          else state <= S_IDLE;
        end
        default: state <= S_IDLE;
      endcase
    end
  end

endmodule

// ==== hw/uart_reg_bank.sv ====
`timescale 1ns/100ps
`include "uart_defs.svh"

module uart_reg_bank (
  input  logic                  clock,
  input  logic                  reset,
  input  uart_pkg::uart_addr_t  addr,
  input  uart_pkg::uart_word_t  wr_data,
  output uart_pkg::uart_word_t  rd_data,
  input  logic                  bank_wr_en,
  input  logic                  bank_rd_en,
  input  logic                  rxdata_wr_en,
  input  uart_pkg::uart_byte_t  rx_fifo_rd_data,
  output uart_pkg::uart_byte_t  tx_fifo_wr_data,
  input  logic                  tx_fifo_full,
  input  logic                  rx_fifo_empty,
  input  uart_pkg::uart_level_t tx_level,
  input  uart_pkg::uart_level_t rx_level,
  output logic                  txen,
  output logic                  nstop,
  output logic                  rxen,
  output logic [15:0]           div,
  output logic                  irq
);

  import uart_pkg::*;

  localparam logic [15:0] DivInit = 16'(`UART_CLOCK_FREQ_HZ / `UART_BAUD_DEFAULT - 1);

  // Bus side, one cycle behind the strobe
  uart_addr_t addr_q;
  uart_word_t wr_data_q;
  uart_addr_t rd_addr;

  uart_byte_t txdata;
  uart_byte_t rxdata;
  logic       rx_empty_q;
  logic [2:0] txcnt;
  logic [2:0] rxcnt;
  logic [1:0] ie;
  logic       tx_pending;
  logic       rx_pending;
  logic       wr_sel;

  always_ff @(posedge clock) begin
    addr_q    <= addr;
    wr_data_q <= wr_data;
  end

  assign wr_sel = bank_wr_en;

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      txdata <= '0;
      txen   <= 1'b0;
      nstop  <= 1'b0;
      txcnt  <= '0;
      rxen   <= 1'b0;
      rxcnt  <= '0;
      ie     <= '0;
      div    <= DivInit;
    end else if (wr_sel) begin
      case (addr_q)
        TXDATA: txdata <= wr_data_q[7:0];
        TXCTRL: begin
          txen  <= wr_data_q[0];
          nstop <= wr_data_q[1];
          txcnt <= wr_data_q[18:16];
        end
        RXCTRL: begin
          rxen  <= wr_data_q[0];
          rxcnt <= wr_data_q[18:16];
        end
        IE:     ie  <= wr_data_q[1:0];
        DIV:    div <= wr_data_q[15:0];
        default: ;
      endcase
    end
  end

  // Empty flag sampled before the pop takes effect
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      rxdata     <= '0;
      rx_empty_q <= 1'b0;
      rd_addr    <= TXDATA;
    end else begin
      if (rxdata_wr_en) begin
        rxdata <= rx_fifo_rd_data;
      end
      if (bank_rd_en) begin
        rd_addr <= addr_q;
        if (addr_q == RXDATA) begin
          rx_empty_q <= rx_fifo_empty;
        end
      end
    end
  end

  // Watermark compare
  assign tx_pending = (tx_level < uart_level_t'(txcnt)) && ie[0];
  assign rx_pending = (rx_level > uart_level_t'(rxcnt)) && ie[1];
  assign irq        = tx_pending || rx_pending;

  assign tx_fifo_wr_data = txdata;

  always_comb begin
    case (rd_addr)
      TXDATA:  rd_data = {tx_fifo_full, 23'b0, txdata};
      RXDATA:  rd_data = {rx_empty_q, 23'b0, rxdata};
      TXCTRL:  rd_data = {13'b0, txcnt, 14'b0, nstop, txen};
      RXCTRL:  rd_data = {13'b0, rxcnt, 15'b0, rxen};
      IE:      rd_data = {30'b0, ie};
      IP:      rd_data = {30'b0, rx_pending, tx_pending};
      DIV:     rd_data = {16'b0, div};
      default: rd_data = '0;
    endcase
  end

  a_rxdata_in_read: assert property (@(posedge clock) disable iff (reset)
    rxdata_wr_en |-> bank_rd_en);

endmodule

// ==== hw/uart_bus_ctrl.sv ====
`timescale 1ns/100ps

module uart_bus_ctrl (
  input  logic                 clock,
  input  logic                 reset,
  input  uart_pkg::uart_addr_t addr,
  input  logic                 wr_en,
  input  logic                 rd_en,
  input  logic                 rx_empty,
  output logic                 bank_wr_en,
  output logic                 bank_rd_en,
  output logic                 rxdata_wr_en,
  output logic                 rx_pop,
  output logic                 tx_push,
  output logic                 rd_valid
);

  import uart_pkg::*;

  uart_addr_t addr_q;
  logic       wr_q;
  logic       rd_q;
  logic       push_q;
  logic       valid_q;

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      addr_q  <= TXDATA;
      wr_q    <= 1'b0;
      rd_q    <= 1'b0;
      push_q  <= 1'b0;
      valid_q <= 1'b0;
    end else begin
      addr_q  <= addr;
      wr_q    <= wr_en;
      rd_q    <= rd_en;
      // Push one cycle after the bank has the new byte
      push_q  <= wr_q && (addr_q == TXDATA);
      valid_q <= rd_q;
    end
  end

  assign bank_wr_en   = wr_q;
  assign bank_rd_en   = rd_q;
  assign rxdata_wr_en = rd_q && (addr_q == RXDATA) && !rx_empty;
  assign rx_pop       = rxdata_wr_en;
  assign tx_push      = push_q;
  assign rd_valid     = valid_q;

  a_wr_rd_exclusive: assert property (@(posedge clock) disable iff (reset)
    !(bank_wr_en && bank_rd_en));

endmodule

// ==== hw/uart_fifo.sv ====
`timescale 1ns/100ps
`include "uart_defs.svh"

module uart_fifo #(
  parameter int DEPTH = `UART_FIFO_DEPTH
) (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  push,
  input  uart_pkg::uart_byte_t  wr_data,
  input  logic                  pop,
  output uart_pkg::uart_byte_t  rd_data,
  output uart_pkg::uart_level_t level,
  output logic                  full,
  output logic                  empty
);

  import uart_pkg::*;

  localparam int PtrW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  uart_byte_t     mem [DEPTH];
  logic [PtrW-1:0] wr_ptr;
  logic [PtrW-1:0] rd_ptr;
  logic           do_push;
  logic           do_pop;

  assign full    = (level == uart_level_t'(DEPTH));
  assign empty   = (level == '0);
  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  // Head always visible
  assign rd_data = mem[rd_ptr];

  always_ff @(posedge clock) begin
    if (do_push) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      level  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == PtrW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PtrW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   level <= level + 1'b1;
        2'b01:   level <= level - 1'b1;
        default: level <= level;
      endcase
    end
  end

  // Overflowing push is dropped
  a_push_full_drop: assert property (@(posedge clock) disable iff (reset)
    push && full && !pop |=> level == $past(level));

  // Consumers only pop when data is there
  a_no_pop_empty: assert property (@(posedge clock) disable iff (reset)
    !(pop && empty));

endmodule

// ==== hw/uart_pkg.sv ====
`include "uart_defs.svh"

package uart_pkg;

  // Register map, SiFive layout; address 7 is reserved
  typedef enum logic [`UART_ADDR_W-1:0] {
    TXDATA = 3'd0,
    RXDATA = 3'd1,
    TXCTRL = 3'd2,
    RXCTRL = 3'd3,
    IE     = 3'd4,
    IP     = 3'd5,
    DIV    = 3'd6
  } uart_addr_t;

  typedef logic [7:0] uart_byte_t;

  typedef logic [31:0] uart_word_t;

  // Holds 0 up to a full FIFO
  typedef logic [$clog2(`UART_FIFO_DEPTH + 1)-1:0] uart_level_t;

endpackage

// ==== include/uart_defs.svh ====
`ifndef UART_DEFS_SVH
`define UART_DEFS_SVH

// System clock feeding the baud counters
`define UART_CLOCK_FREQ_HZ 125000000

// Line rate after reset
`define UART_BAUD_DEFAULT 115200

// Entries in each of the tx and rx FIFOs
`define UART_FIFO_DEPTH 8

// Word address into the register bank
`define UART_ADDR_W 3

`endif
